//--- Makefile
# Verilator build and run for the instruction cache testbench

TOP := instrCacheTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f --Mdir obj_dir -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "Testbench reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

//--- sources.f
verilog/icachePkg.sv
verilog/icacheWay.sv
verilog/icacheController.sv
verilog/instrCache.sv
verification/busMemoryModel.sv
verification/instrCacheTb.sv

//--- verification/busMemoryModel.sv
//--------------------------------------------------------------------------
// Testbench memory on the wide block bus of the instruction cache
// Answers each block read after a random latency of 1 to 6 cycles with
// a one-cycle BusReady strobe. Word contents follow a fixed rule on the
// word address, so the testbench can predict every fetched word.
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module busMemoryModel #(
    parameter int BlockSize = icachePkg::DefaultBlockSize
) (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    // Block read request from the cache
    input  wire logic                                      BusRead,
    input  wire logic [icachePkg::AddrWidth-1:0]           HAddr,
    // Block data, valid with the strobe
    output logic [BlockSize*icachePkg::WordWidth-1:0]      HRData,
    output logic                                           BusReady
);

    import icachePkg::*;

    localparam int MaxLatency = 6;

    // Read in progress and cycles left until the strobe
    bit pending;
    int waitLeft;

    // Word at a word address: multiply by the golden ratio constant, then XOR
    function automatic logic [WordWidth-1:0] ruleWord(input logic [AddrWidth-1:0] wordAddr);
        return (wordAddr * 32'h9E37_79B1) ^ 32'hA5A5_A5A5;
    endfunction

    //----------------------------------------------------------------------
    // Response process, driven 2 ns after each rising edge
    //----------------------------------------------------------------------

    initial begin
        BusReady = 1'b0;
        HRData   = '0;
        pending  = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #2;
            if (reset) begin
                BusReady = 1'b0;
                pending  = 1'b0;
            end else if (BusReady) begin
                // Strobe lasts one cycle
                BusReady = 1'b0;
                pending  = 1'b0;
            end else if (pending) begin
                waitLeft--;
                if (waitLeft == 0) begin
                    // Whole block, lowest word first
                    for (int i = 0; i < BlockSize; i++) begin
                        HRData[i*WordWidth +: WordWidth] = ruleWord((HAddr >> 2) + 32'(i));
                    end
                    BusReady = 1'b1;
                end
            end else if (BusRead) begin
                // New request, latency counted from this cycle
                pending  = 1'b1;
                waitLeft = 1 + int'($urandom % MaxLatency);
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/instrCacheTb.sv
//--------------------------------------------------------------------------
// Testbench for the two-way instruction cache
// Runs directed cold miss, hit, set conflict and replacement tests, a
// seeded random fetch run and a reset in mid-run. A reference model of
// tags, valid bits and replacement bits predicts every hit and miss.
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module instrCacheTb;

    import icachePkg::*;

    localparam int Period          = 40;
    localparam int ResetCycles     = 10;
    localparam int RandomFetches   = 400;
    localparam int DirectedFetches = 40;
    localparam int MaxFetchCycles  = 8;
    localparam int StallLimit      = 20;
    localparam int BlockShift      = $clog2(DefaultBlockSize) + 2;
    localparam int SetBits         = $clog2(DefaultLines);
    localparam logic [AddrWidth-1:0] RandomBase = 32'h0000_2000;

    logic                                  clk;
    logic                                  reset;
    logic [AddrWidth-1:0]                  a;
    logic [DefaultBlockSize*WordWidth-1:0] HRData;
    logic                                  BusReady;
    logic [WordWidth-1:0]                  RD;
    logic                                  IStall;
    logic                                  BusRead;
    logic [AddrWidth-1:0]                  HAddr;

    int   errorCount;
    int   testErrors;
    int   testsRun;
    int   testsFailed;
    int   readCount;
    logic prevBusRead;

    // Reference model, way index 0 is way one
    bit                   modelValid   [DefaultLines][2];
    logic [AddrWidth-1:0] modelTag     [DefaultLines][2];
    bit                   modelLastTwo [DefaultLines];

    instrCache #(.BlockSize(DefaultBlockSize), .Lines(DefaultLines)) UUT (
        .clk(clk), .reset(reset), .a(a), .HRData(HRData), .BusReady(BusReady),
        .RD(RD), .IStall(IStall), .BusRead(BusRead), .HAddr(HAddr)
    );

    busMemoryModel #(.BlockSize(DefaultBlockSize)) memory (
        .clk(clk), .reset(reset), .BusRead(BusRead), .HAddr(HAddr),
        .HRData(HRData), .BusReady(BusReady)
    );

    always #(Period / 2) clk = ~clk;

    // Count block reads by their rising edge
    always @(negedge clk) begin
        if (BusRead && !prevBusRead) begin
            readCount++;
        end
        prevBusRead = BusRead;
    end

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------

    function automatic logic [WordWidth-1:0] expectedWord(input logic [AddrWidth-1:0] addr);
        logic [WordWidth-1:0] wordAddr;
        wordAddr = addr >> 2;
        return (wordAddr * 32'h9E37_79B1) ^ 32'hA5A5_A5A5;
    endfunction

    function automatic int setOf(input logic [AddrWidth-1:0] addr);
        return int'((addr >> BlockShift) % DefaultLines);
    endfunction

    function automatic logic [AddrWidth-1:0] tagOf(input logic [AddrWidth-1:0] addr);
        return addr >> (BlockShift + SetBits);
    endfunction

    function automatic logic [AddrWidth-1:0] blockAddr(input logic [AddrWidth-1:0] tag,
                                                       input int setIdx);
        return (tag << (BlockShift + SetBits)) | (32'(setIdx) << BlockShift);
    endfunction

    function automatic bit modelHit(input logic [AddrWidth-1:0] addr);
        int s;
        s = setOf(addr);
        return (modelValid[s][0] && modelTag[s][0] == tagOf(addr))
            || (modelValid[s][1] && modelTag[s][1] == tagOf(addr));
    endfunction

    // Empty way if exactly one is valid, else the way not filled last
    function automatic int modelVictim(input int s);
        if (modelValid[s][0] != modelValid[s][1]) begin
            return modelValid[s][0] ? 1 : 0;
        end
        return modelLastTwo[s] ? 0 : 1;
    endfunction

    task automatic modelFill(input logic [AddrWidth-1:0] addr);
        int s;
        int w;
        s = setOf(addr);
        if (!modelHit(addr)) begin
            w = modelVictim(s);
            modelValid[s][w]  = 1'b1;
            modelTag[s][w]    = tagOf(addr);
            modelLastTwo[s]   = (w == 1);
        end
    endtask

    task automatic modelClear();
        for (int s = 0; s < DefaultLines; s++) begin
            modelValid[s][0] = 1'b0;
            modelValid[s][1] = 1'b0;
            modelLastTwo[s]  = 1'b0;
        end
    endtask

    //----------------------------------------------------------------------
    // Checks and bookkeeping
    //----------------------------------------------------------------------

    task automatic reportError(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errorCount++;
    endtask

    task automatic beginTest();
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount != testErrors) begin
            testsFailed++;
            $display("Test %0d %s: FAIL, %0d errors", testsRun, name, errorCount - testErrors);
        end else begin
            $display("Test %0d %s: pass", testsRun, name);
        end
    endtask

    // Called 2 ns after an edge, returns 2 ns after the edge that ends the fetch
    task automatic doFetch(input logic [AddrWidth-1:0] addr, input bit expectHit);
        logic [AddrWidth-1:0] aligned;
        int                   stallCycles;
        aligned     = addr & ~((32'd1 << BlockShift) - 32'd1);
        stallCycles = 0;
        a = addr;
        @(negedge clk);
        if (IStall == expectHit) begin
            reportError($sformatf("address %h hit=%0b, expected %0b", addr, !IStall, expectHit));
        end
        if (!IStall && BusRead) begin
            reportError($sformatf("BusRead high on a hit at address %h", addr));
        end
        // Miss wait, bus request held until the strobe
        while (IStall && stallCycles < StallLimit) begin
            @(negedge clk);
            stallCycles++;
            if (!BusRead) begin
                reportError($sformatf("BusRead low during miss of address %h", addr));
            end
            if (HAddr !== aligned) begin
                reportError($sformatf("HAddr %h, expected %h", HAddr, aligned));
            end
        end
        if (IStall) begin
            $display("Fetch of address %h still stalled after %0d cycles", addr, StallLimit);
            errorCount++;
        end else if (RD !== expectedWord(addr)) begin
            reportError($sformatf("RD %h, expected %h at address %h",
                                  RD, expectedWord(addr), addr));
        end
        modelFill(addr);
        @(posedge clk);
        #2;
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------

    initial begin
        logic [AddrWidth-1:0] addr;
        logic [AddrWidth-1:0] newAddr;
        logic [AddrWidth-1:0] keptAddr;
        logic [AddrWidth-1:0] evictedAddr;
        int                   s;
        int                   victim;
        int                   readsBefore;
        int                   modelMisses;
        bit                   predictHit;
        void'($urandom(37));
        clk         = 1'b0;
        reset       = 1'b1;
        a           = '0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        readCount   = 0;
        prevBusRead = 1'b0;
        modelClear();
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;

        // Four blocks over both sets, all cold
        beginTest();
        readsBefore = readCount;
        for (int i = 0; i < 4; i++) begin
            doFetch(32'h0000_0044 + 32'(i) * 32'h10, 1'b0);
        end
        if (readCount - readsBefore != 4) begin
            reportError($sformatf("%0d block reads, expected 4", readCount - readsBefore));
        end
        endTest("cold misses");

        // Every word of the block filled last
        beginTest();
        for (int i = 0; i < DefaultBlockSize; i++) begin
            doFetch(32'h0000_0070 + 32'(i) * 32'h4, 1'b1);
        end
        endTest("hits");

        // Blocks 0x40 and 0x60 share set 0
        beginTest();
        readsBefore = readCount;
        for (int i = 0; i < 8; i++) begin
            doFetch((i % 2 == 0) ? 32'h0000_0048 : 32'h0000_006C, 1'b1);
        end
        if (readCount != readsBefore) begin
            reportError($sformatf("%0d block reads in a full set", readCount - readsBefore));
        end
        endTest("two tags per set");

        // Third tag in set 0
        beginTest();
        newAddr     = 32'h0000_0080;
        s           = setOf(newAddr);
        victim      = modelVictim(s);
        evictedAddr = blockAddr(modelTag[s][victim], s);
        keptAddr    = blockAddr(modelTag[s][1 - victim], s);
        doFetch(newAddr, 1'b0);
        doFetch(keptAddr, 1'b1);
        doFetch(evictedAddr, 1'b0);
        endTest("replacement");

        // Random word fetches in a 256-byte window
        beginTest();
        readsBefore = readCount;
        modelMisses = 0;
        addr        = RandomBase;
        for (int i = 0; i < RandomFetches; i++) begin
            addr       = RandomBase + 32'($urandom % 64) * 32'h4;
            predictHit = modelHit(addr);
            if (!predictHit) begin
                modelMisses++;
            end
            doFetch(addr, predictHit);
        end
        if (readCount - readsBefore != modelMisses) begin
            reportError($sformatf("%0d block reads, model misses %0d",
                                  readCount - readsBefore, modelMisses));
        end
        endTest("random run");

        // Last random block is resident until the reset
        beginTest();
        reset = 1'b1;
        @(negedge clk);
        if (BusRead !== 1'b0) begin
            reportError("BusRead high during reset");
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        modelClear();
        doFetch(addr, 1'b0);
        endTest("reset mid-run");

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Reset time plus the worst case of every fetch
    initial begin
        #(Period * (ResetCycles + (RandomFetches + DirectedFetches) * MaxFetchCycles));
        $display("Watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/icacheController.sv
//--------------------------------------------------------------------------
// Miss controller for the instruction cache
// Two states: Idle serves hits, Fetch holds a block read on the bus
// until the memory strobes BusReady. In the strobe cycle the fill is
// written and the word is forwarded from the bus, so the core sees
// the stall drop in that same cycle.
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module icacheController (
    input  wire logic clk,
    input  wire logic reset,
    // Lookup result for the current address
    input  wire logic Hit,
    // One-cycle strobe, block valid on the bus
    input  wire logic BusReady,
    // Cache write enable, fill the chosen way
    output logic      CWE,
    // Forward bus data instead of cache data
    output logic      RDSel,
    // Hold the fetch stage
    output logic      IStall,
    // Block read request level
    output logic      BusRead
);

    import icachePkg::*;

    CacheState state;
    CacheState nextState;

    //----------------------------------------------------------------------
    // State register
    //----------------------------------------------------------------------

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    //----------------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------------

    always_comb begin
        nextState = state;
        case (state)
            // A miss starts a block read at the next edge
            Idle: begin
                if (!Hit) begin
                    nextState = Fetch;
                end
            end
            // Stay until the bus delivers the block
            Fetch: begin
                if (BusReady) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    //----------------------------------------------------------------------
    // Outputs
    //----------------------------------------------------------------------

    // Request held for the whole wait, strobe cycle included
    assign BusRead = (state == Fetch);

    // Fill and forward only in the strobe cycle
    assign CWE   = (state == Fetch) && BusReady;
    assign RDSel = (state == Fetch) && BusReady;

    // Idle stalls on a miss; Fetch stalls until the block arrives
    assign IStall = (state == Idle) ? !Hit : !BusReady;

    // Memory only answers an outstanding read
    assert property (@(posedge clk) disable iff (reset)
        (state == Idle) |-> !BusReady)
        else $error("BusReady seen with no block read outstanding");

endmodule

`default_nettype wire

//--- verilog/icachePkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the two-way instruction cache
// Word and address widths, the miss controller states and the default
// cache geometry; the RTL and the bus memory model import this package
//--------------------------------------------------------------------------
`default_nettype none

package icachePkg;

    //----------------------------------------------------------------------
    // Data path widths
    //----------------------------------------------------------------------

    // One instruction, also one word on the wide bus
    localparam int WordWidth = 32;

    // Byte address presented by the fetch stage
    localparam int AddrWidth = 32;

    //----------------------------------------------------------------------
    // Default geometry, overridden at the cache top level
    //----------------------------------------------------------------------

    // Words per block, power of two and at least 2
    localparam int DefaultBlockSize = 4;

    // Number of sets, power of two
    localparam int DefaultLines = 2;

    //----------------------------------------------------------------------
    // Miss controller states
    //----------------------------------------------------------------------

    // Idle serves hits, Fetch waits on the block read
    typedef enum logic {
        Idle,
        Fetch
    } CacheState;

endpackage

`default_nettype wire

//--- verilog/icacheWay.sv
//--------------------------------------------------------------------------
// One way of the set-associative instruction cache
// Holds a valid flag, a tag and a whole block per set. Reads are
// combinational by set index; a write stores tag and block together
// and marks the set valid. Instantiated twice by the cache top level.
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module icacheWay #(
    parameter int Lines     = 2,
    parameter int TagBits   = 27,
    parameter int BlockSize = 4
) (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    // Lookup and fill index
    input  wire logic [$clog2(Lines)-1:0]                set,
    // Tag of the current fetch address
    input  wire logic [TagBits-1:0]                      tag,
    // Block from the bus, written on a fill
    input  wire logic [BlockSize*icachePkg::WordWidth-1:0] wd,
    input  wire logic                                    we,
    // Lookup results
    output logic                                         valid,
    output logic [TagBits-1:0]                           storedTag,
    output logic [BlockSize*icachePkg::WordWidth-1:0]    rd
);

    import icachePkg::*;

    localparam int BlockBits = BlockSize * WordWidth;

    //----------------------------------------------------------------------
    // Storage
    //----------------------------------------------------------------------

    // One flag per set, cleared by reset
    logic [Lines-1:0] validBits;

    // Tag and block arrays
    logic [TagBits-1:0]   tagMem   [Lines];
    logic [BlockBits-1:0] blockMem [Lines];

    // Valid flags
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            validBits <= '0;
        end else if (we) begin
            validBits[set] <= 1'b1;
        end
    end

    // Tag and block written together on a fill
    always_ff @(posedge clk) begin
        if (we) begin
            tagMem[set]   <= tag;
            blockMem[set] <= wd;
        end
    end

    //----------------------------------------------------------------------
    // Combinational read
    //----------------------------------------------------------------------

    // Same-cycle lookup for the hit path
    assign valid     = validBits[set];
    assign storedTag = tagMem[set];
    assign rd        = blockMem[set];

endmodule

`default_nettype wire

//--- verilog/instrCache.sv
//--------------------------------------------------------------------------
// Two-way set-associative read-only instruction cache
// Hits return the word in the same cycle. A miss stalls the core,
// reads the whole block over the wide bus and forwards the requested
// word from the bus data while the block is written into one way.
// Replacement keeps one bit per set naming the way filled last.
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module instrCache #(
    parameter int BlockSize = icachePkg::DefaultBlockSize,
    parameter int Lines     = icachePkg::DefaultLines
) (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    // Fetch byte address, held stable while stalled
    input  wire logic [icachePkg::AddrWidth-1:0]          a,
    // Whole block from memory, valid with BusReady
    input  wire logic [BlockSize*icachePkg::WordWidth-1:0] HRData,
    input  wire logic                                    BusReady,
    // Instruction for a, valid when IStall is low
    output logic [icachePkg::WordWidth-1:0]              RD,
    output logic                                         IStall,
    // Block read request and its aligned address
    output logic                                         BusRead,
    output logic [icachePkg::AddrWidth-1:0]              HAddr
);

    import icachePkg::*;

    // Address split into tag, set, word offset and byte offset
    localparam int SetBits    = $clog2(Lines);
    localparam int OffsetBits = $clog2(BlockSize);
    localparam int TagBits    = 30 - OffsetBits - SetBits;
    localparam int BlockBits  = BlockSize * WordWidth;

    logic [TagBits-1:0]    tag;
    logic [SetBits-1:0]    setIdx;
    logic [OffsetBits-1:0] wordOffset;

    // Per way lookup results
    logic                 wayOneValid;
    logic                 wayTwoValid;
    logic [TagBits-1:0]   wayOneTag;
    logic [TagBits-1:0]   wayTwoTag;
    logic [BlockBits-1:0] wayOneBlock;
    logic [BlockBits-1:0] wayTwoBlock;
    logic                 wayOneHit;
    logic                 wayTwoHit;
    logic                 hit;

    // Fill control
    logic cacheWe;
    logic busDataSel;
    logic wayOneEn;
    logic wayTwoEn;
    logic wayOneWe;
    logic wayTwoWe;

    // Set bit high when way two was the last one filled
    logic [Lines-1:0] lastFillTwo;

    // Block feeding the word selector
    logic [BlockBits-1:0] srcBlock;

    assign tag        = a[AddrWidth-1 -: TagBits];
    assign setIdx     = a[OffsetBits+2 +: SetBits];
    assign wordOffset = a[2 +: OffsetBits];

    // Block-aligned request address
    assign HAddr = {a[AddrWidth-1:OffsetBits+2], {(OffsetBits+2){1'b0}}};

    //----------------------------------------------------------------------
    // Storage ways and miss controller
    //----------------------------------------------------------------------

    icacheWay #(.Lines(Lines), .TagBits(TagBits), .BlockSize(BlockSize)) wayOne (
        .clk       (clk),
        .reset     (reset),
        .set       (setIdx),
        .tag       (tag),
        .wd        (HRData),
        .we        (wayOneWe),
        .valid     (wayOneValid),
        .storedTag (wayOneTag),
        .rd        (wayOneBlock)
    );

    icacheWay #(.Lines(Lines), .TagBits(TagBits), .BlockSize(BlockSize)) wayTwo (
        .clk       (clk),
        .reset     (reset),
        .set       (setIdx),
        .tag       (tag),
        .wd        (HRData),
        .we        (wayTwoWe),
        .valid     (wayTwoValid),
        .storedTag (wayTwoTag),
        .rd        (wayTwoBlock)
    );

    icacheController controller (
        .clk      (clk),
        .reset    (reset),
        .Hit      (hit),
        .BusReady (BusReady),
        .CWE      (cacheWe),
        .RDSel    (busDataSel),
        .IStall   (IStall),
        .BusRead  (BusRead)
    );

    //----------------------------------------------------------------------
    // Hit detection
    //----------------------------------------------------------------------

    assign wayOneHit = wayOneValid && (wayOneTag == tag);
    assign wayTwoHit = wayTwoValid && (wayTwoTag == tag);
    assign hit       = wayOneHit || wayTwoHit;

    //----------------------------------------------------------------------
    // Way selection and replacement
    //----------------------------------------------------------------------

    always_comb begin
        if (wayOneHit || wayTwoHit) begin
            // Hitting way
            wayOneEn = wayOneHit;
            wayTwoEn = wayTwoHit;
        end else if (wayOneValid ^ wayTwoValid) begin
            // Fill the empty way
            wayOneEn = !wayOneValid;
            wayTwoEn = !wayTwoValid;
        end else begin
            // Victim is the way not filled last
            wayOneEn = lastFillTwo[setIdx];
            wayTwoEn = !lastFillTwo[setIdx];
        end
    end

    assign wayOneWe = wayOneEn && cacheWe;
    assign wayTwoWe = wayTwoEn && cacheWe;

    // Updated on fills only, hits leave it alone
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            lastFillTwo <= '0;
        end else if (cacheWe) begin
            lastFillTwo[setIdx] <= wayTwoWe;
        end
    end

    //----------------------------------------------------------------------
    // Output word
    //----------------------------------------------------------------------

    // Bus block on a fill, otherwise the hitting way
    assign srcBlock = busDataSel ? HRData : (wayOneHit ? wayOneBlock : wayTwoBlock);

    // One selector for any block size
    assign RD = srcBlock[wordOffset*WordWidth +: WordWidth];

    // Tags within a set stay distinct
    assert property (@(posedge clk) disable iff (reset)
        !(wayOneHit && wayTwoHit))
        else $error("Both ways hit the same address");

    // At most one way written in any cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({wayOneWe, wayTwoWe}))
        else $error("Both way write enables active in the same cycle");

endmodule

`default_nettype wire
